//--- compile.f
+incdir+source
source/fv_mem_pkg.sv
source/fv_ctrl_pkg.sv
source/fv_sram_if.sv
source/fv_sram.sv
source/fv_bank_ctrl.sv
source/fv_buffer_top.sv
test/fv_checker.sv
test/tb_fv_buffer.sv

//--- run.sh
#!/bin/sh
# build the feature-vector buffer testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tb_fv_buffer -o tb_fv_buffer
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/tb_fv_buffer)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^STATUS: PASS$"; then
    exit 0
fi
exit 1

//--- source/fv_bank_ctrl.sv
// ********************
// bank controller for write bursts, tagged reads and node streaming
// ********************
`timescale 1ns/1ns
`include "fv_defines.svh"

module fv_bank_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  fv_mem_pkg::fv_req_t   req,
    input  logic                  stream_begin,
    input  logic [`FV_NODE_W:0]   fv_num,
    fv_sram_if.ctrl               sram,
    output logic                  rd_valid,
    output logic                  rd_sos,
    output logic                  rd_eos,
    output logic [`FV_TAG_W-1:0]  rd_tag,
    output logic [`FV_WIDTH-1:0]  rd_data,
    output logic                  st_valid,
    output logic                  st_sos,
    output logic                  st_eos,
    output logic [`FV_NODE_W-1:0] st_node,
    output logic [`FV_WIDTH-1:0]  st_data,
    output logic                  idle
);

    localparam int BEAT_W = `FV_ADDR_W - `FV_NODE_W;
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`FV_BEATS - 1);

    fv_ctrl_pkg::bank_state_e state;
    logic [BEAT_W-1:0]     beat_cnt;
    logic [`FV_NODE_W-1:0] node_reg;
    logic [`FV_TAG_W-1:0]  tag_reg;
    logic [`FV_NODE_W:0]   num_reg;

    logic last_beat;
    logic last_node;
    logic st_go;
    logic st_start;
    logic rd_start;
    logic wr_start;
    logic wr_beat;
    logic issue;

    // stage aligned with the registered sram read word
    logic                  p1_valid;
    logic                  p1_stream;
    logic                  p1_sos;
    logic                  p1_eos;
    logic [`FV_TAG_W-1:0]  p1_tag;
    logic [`FV_NODE_W-1:0] p1_node;

    assign last_beat = (beat_cnt == LAST_BEAT);
    assign last_node = ({1'b0, node_reg} == num_reg - 1'b1);

    // busy until the last output beat has left
    assign idle = (state == fv_ctrl_pkg::ST_IDLE) && !p1_valid && !rd_valid && !st_valid;

    // a stream pulse wins over a request in the same cycle
    assign st_go    = stream_begin && (fv_num != '0);
    assign st_start = idle && st_go;
    assign rd_start = idle && !st_go && req.valid && (req.op == fv_mem_pkg::OP_READ);
    assign wr_start = idle && !st_go && req.valid && (req.op == fv_mem_pkg::OP_WRITE)
                      && req.wr_sos;
    assign wr_beat  = (state == fv_ctrl_pkg::ST_WRITE) && req.valid
                      && (req.op == fv_mem_pkg::OP_WRITE);
    assign issue    = (state == fv_ctrl_pkg::ST_READ) || (state == fv_ctrl_pkg::ST_STREAM);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= fv_ctrl_pkg::ST_IDLE;
            beat_cnt <= '0;
            node_reg <= '0;
        end else begin
            case (state)
                fv_ctrl_pkg::ST_IDLE: begin
                    if (st_start) begin
                        state    <= fv_ctrl_pkg::ST_STREAM;
                        node_reg <= '0;
                        beat_cnt <= '0;
                    end else if (rd_start) begin
                        state    <= fv_ctrl_pkg::ST_READ;
                        node_reg <= req.node_id;
                        beat_cnt <= '0;
                    end else if (wr_start && !req.wr_eos) begin
                        // beat 0 is already written at this edge
                        state    <= fv_ctrl_pkg::ST_WRITE;
                        node_reg <= req.node_id;
                        beat_cnt <= BEAT_W'(1);
                    end
                end
                fv_ctrl_pkg::ST_WRITE: begin
                    if (wr_beat) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (req.wr_eos) begin
                            state    <= fv_ctrl_pkg::ST_IDLE;
                            beat_cnt <= '0;
                        end
                    end
                end
                fv_ctrl_pkg::ST_READ: begin
                    beat_cnt <= beat_cnt + 1'b1;
                    if (last_beat) begin
                        state    <= fv_ctrl_pkg::ST_IDLE;
                        beat_cnt <= '0;
                    end
                end
                fv_ctrl_pkg::ST_STREAM: begin
                    beat_cnt <= beat_cnt + 1'b1;
                    if (last_beat) begin
                        beat_cnt <= '0;
                        if (last_node) begin
                            state <= fv_ctrl_pkg::ST_IDLE;
                        end else begin
                            node_reg <= node_reg + 1'b1;
                        end
                    end
                end
                default: state <= fv_ctrl_pkg::ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_start) begin
            tag_reg <= req.pe_tag;
        end
        if (st_start) begin
            num_reg <= fv_num;
        end
    end

    // sos write beat goes out in the cycle it arrives
    always_comb begin
        sram.cen   = 1'b1;
        sram.wen   = 1'b1;
        sram.addr  = {node_reg, beat_cnt};
        sram.wdata = req.data;
        if (wr_start) begin
            sram.cen  = 1'b0;
            sram.wen  = 1'b0;
            sram.addr = {req.node_id, BEAT_W'(0)};
        end else if (wr_beat) begin
            sram.cen = 1'b0;
            sram.wen = 1'b0;
        end else if (issue) begin
            sram.cen = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            p1_valid  <= 1'b0;
            p1_stream <= 1'b0;
            p1_sos    <= 1'b0;
            p1_eos    <= 1'b0;
            rd_valid  <= 1'b0;
            rd_sos    <= 1'b0;
            rd_eos    <= 1'b0;
            st_valid  <= 1'b0;
            st_sos    <= 1'b0;
            st_eos    <= 1'b0;
        end else begin
            p1_valid  <= issue;
            p1_stream <= (state == fv_ctrl_pkg::ST_STREAM);
            p1_sos    <= (beat_cnt == '0);
            p1_eos    <= last_beat;
            rd_valid  <= p1_valid && !p1_stream;
            rd_sos    <= p1_valid && !p1_stream && p1_sos;
            rd_eos    <= p1_valid && !p1_stream && p1_eos;
            st_valid  <= p1_valid && p1_stream;
            st_sos    <= p1_valid && p1_stream && p1_sos;
            st_eos    <= p1_valid && p1_stream && p1_eos;
        end
    end

    always_ff @(posedge clk) begin
        p1_tag  <= tag_reg;
        p1_node <= node_reg;
        if (p1_valid && !p1_stream) begin
            rd_tag  <= p1_tag;
            rd_data <= sram.rdata;
        end
        if (p1_valid && p1_stream) begin
            st_node <= p1_node;
            st_data <= sram.rdata;
        end
    end

endmodule

//--- source/fv_buffer_top.sv
// ********************
// large feature-vector buffer of four controller/sram banks
// ********************
`timescale 1ns/1ns
`include "fv_defines.svh"

module fv_buffer_top (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic [`FV_NUM_BANKS-1:0]                      req_valid,
    input  logic [`FV_NUM_BANKS-1:0]                      req_op,
    input  logic [`FV_NUM_BANKS-1:0]                      req_wr_sos,
    input  logic [`FV_NUM_BANKS-1:0]                      req_wr_eos,
    input  logic [`FV_NUM_BANKS-1:0][`FV_TAG_W-1:0]       req_pe_tag,
    input  logic [`FV_NUM_BANKS-1:0][`FV_NODE_W-1:0]      req_node_id,
    input  logic [`FV_NUM_BANKS-1:0][`FV_WIDTH-1:0]       req_data,
    input  logic                                          stream_begin,
    input  logic [`FV_NODE_W:0]                           fv_num,
    output logic [`FV_NUM_BANKS-1:0]                      rd_valid,
    output logic [`FV_NUM_BANKS-1:0]                      rd_sos,
    output logic [`FV_NUM_BANKS-1:0]                      rd_eos,
    output logic [`FV_NUM_BANKS-1:0][`FV_TAG_W-1:0]       rd_tag,
    output logic [`FV_NUM_BANKS-1:0][`FV_WIDTH-1:0]       rd_data,
    output logic [`FV_NUM_BANKS-1:0]                      st_valid,
    output logic [`FV_NUM_BANKS-1:0]                      st_sos,
    output logic [`FV_NUM_BANKS-1:0]                      st_eos,
    output logic [`FV_NUM_BANKS-1:0][`FV_NODE_W-1:0]      st_node,
    output logic [`FV_NUM_BANKS-1:0][`FV_WIDTH-1:0]       st_data,
    output logic                                          available
);

    fv_mem_pkg::fv_req_t [`FV_NUM_BANKS-1:0] req_pkt;
    logic [`FV_NUM_BANKS-1:0] bank_idle;

    // requesters may only send while every bank is idle
    assign available = &bank_idle;

    for (genvar i = 0; i < `FV_NUM_BANKS; i++) begin : g_bank
        fv_sram_if u_sram_if ();

        assign req_pkt[i].valid   = req_valid[i];
        assign req_pkt[i].op      = fv_mem_pkg::req_op_e'(req_op[i]);
        assign req_pkt[i].pe_tag  = req_pe_tag[i];
        assign req_pkt[i].node_id = req_node_id[i];
        assign req_pkt[i].data    = req_data[i];
        assign req_pkt[i].wr_sos  = req_wr_sos[i];
        assign req_pkt[i].wr_eos  = req_wr_eos[i];

        fv_bank_ctrl u_bank_ctrl (
            .clk          (clk),
            .rst_n        (rst_n),
            .req          (req_pkt[i]),
            .stream_begin (stream_begin),
            .fv_num       (fv_num),
            .sram         (u_sram_if.ctrl),
            .rd_valid     (rd_valid[i]),
            .rd_sos       (rd_sos[i]),
            .rd_eos       (rd_eos[i]),
            .rd_tag       (rd_tag[i]),
            .rd_data      (rd_data[i]),
            .st_valid     (st_valid[i]),
            .st_sos       (st_sos[i]),
            .st_eos       (st_eos[i]),
            .st_node      (st_node[i]),
            .st_data      (st_data[i]),
            .idle         (bank_idle[i])
        );

        fv_sram u_sram (
            .clk (clk),
            .mem (u_sram_if.mem)
        );
    end

endmodule

//--- source/fv_ctrl_pkg.sv
// ********************
// bank controller types
// ********************
package fv_ctrl_pkg;

    // bank controller states
    typedef enum logic [1:0] {
        // waiting for a request or a stream pulse
        ST_IDLE   = 2'd0,
        // collecting the rest of a write burst
        ST_WRITE  = 2'd1,
        // issuing the beats of one tagged read
        ST_READ   = 2'd2,
        // issuing every beat of nodes 0 to fv_num-1
        ST_STREAM = 2'd3
    } bank_state_e;

endpackage

//--- source/fv_defines.svh
// ********************
// feature-vector buffer sizes
// ********************
`ifndef FV_DEFINES_SVH
`define FV_DEFINES_SVH

// independent controller/sram pairs
`define FV_NUM_BANKS 4

// bits per beat on every data path
`define FV_WIDTH 32

// beats in one feature vector
`define FV_BEATS 4

// local node index over 64 nodes per bank
`define FV_NODE_W 6

// edge pe tag carried with read requests
`define FV_TAG_W 2

// sram address is {node, beat}
`define FV_ADDR_W (`FV_NODE_W + $clog2(`FV_BEATS))

`endif

//--- source/fv_mem_pkg.sv
// ********************
// request types of the feature-vector buffer
// ********************
`include "fv_defines.svh"

package fv_mem_pkg;

    // request opcode
    typedef enum logic [0:0] {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } req_op_e;

    // one request beat on a bank port
    typedef struct packed {
        logic                  valid;
        req_op_e               op;
        logic [`FV_TAG_W-1:0]  pe_tag;
        // node index of a read or of the sos write beat
        logic [`FV_NODE_W-1:0] node_id;
        logic [`FV_WIDTH-1:0]  data;
        logic                  wr_sos;
        logic                  wr_eos;
    } fv_req_t;

endpackage

//--- source/fv_sram.sv
// ********************
// single-port sram of one bank
// ********************
`timescale 1ns/1ns
`include "fv_defines.svh"

module fv_sram (
    input logic    clk,
    fv_sram_if.mem mem
);

    localparam int DEPTH = 2 ** `FV_ADDR_W;

    logic [`FV_WIDTH-1:0] mem_array [DEPTH];

    // write when cen and wen are low, otherwise read into rdata
    always_ff @(posedge clk) begin
        if (!mem.cen) begin
            if (!mem.wen) begin
                mem_array[mem.addr] <= mem.wdata;
            end else begin
                mem.rdata <= mem_array[mem.addr];
            end
        end
    end

    // rdata holds its last word while the bank is not reading

endmodule

//--- source/fv_sram_if.sv
// ********************
// command and read data path between a bank controller and its sram
// ********************
`timescale 1ns/1ns
`include "fv_defines.svh"

interface fv_sram_if;

    // active low chip enable and write enable
    logic                  cen;
    logic                  wen;
    logic [`FV_ADDR_W-1:0] addr;
    logic [`FV_WIDTH-1:0]  wdata;
    // registered read word one cycle after the command
    logic [`FV_WIDTH-1:0]  rdata;

    modport ctrl (
        output cen,
        output wen,
        output addr,
        output wdata,
        input  rdata
    );

    modport mem (
        input  cen,
        input  wen,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

//--- test/fv_checker.sv
// ********************
// reference model of the banks and comparison of every output beat
// ********************
`timescale 1ns/1ns
`include "fv_defines.svh"

module fv_checker (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic [3:0]                               test_id,
    input  logic [`FV_NUM_BANKS-1:0]                 req_valid,
    input  logic [`FV_NUM_BANKS-1:0]                 req_op,
    input  logic [`FV_NUM_BANKS-1:0]                 req_wr_sos,
    input  logic [`FV_NUM_BANKS-1:0]                 req_wr_eos,
    input  logic [`FV_NUM_BANKS-1:0][`FV_TAG_W-1:0]  req_pe_tag,
    input  logic [`FV_NUM_BANKS-1:0][`FV_NODE_W-1:0] req_node_id,
    input  logic [`FV_NUM_BANKS-1:0][`FV_WIDTH-1:0]  req_data,
    input  logic                                     stream_begin,
    input  logic [`FV_NODE_W:0]                      fv_num,
    input  logic [`FV_NUM_BANKS-1:0]                 rd_valid,
    input  logic [`FV_NUM_BANKS-1:0]                 rd_sos,
    input  logic [`FV_NUM_BANKS-1:0]                 rd_eos,
    input  logic [`FV_NUM_BANKS-1:0][`FV_TAG_W-1:0]  rd_tag,
    input  logic [`FV_NUM_BANKS-1:0][`FV_WIDTH-1:0]  rd_data,
    input  logic [`FV_NUM_BANKS-1:0]                 st_valid,
    input  logic [`FV_NUM_BANKS-1:0]                 st_sos,
    input  logic [`FV_NUM_BANKS-1:0]                 st_eos,
    input  logic [`FV_NUM_BANKS-1:0][`FV_NODE_W-1:0] st_node,
    input  logic [`FV_NUM_BANKS-1:0][`FV_WIDTH-1:0]  st_data,
    input  logic                                     available,
    output int                                       value_errs,
    output int                                       order_errs,
    output int                                       pending
);

    localparam int NB = `FV_NUM_BANKS;
    localparam int NW = `FV_NODE_W;
    localparam int BW = $clog2(`FV_BEATS);
    localparam int W  = `FV_WIDTH;

    typedef struct packed {
        int                   cyc;
        logic                 sos;
        logic                 eos;
        logic [`FV_TAG_W-1:0] tag;
        logic [NW-1:0]        node;
        logic [BW-1:0]        beat;
    } beat_t;

    logic [W-1:0]  shadow [NB][2**`FV_ADDR_W];
    // read queues first, then stream queues
    beat_t         exp_q [2*NB][$];
    int            busy_to [NB];
    logic          wr_act [NB];
    logic [NW-1:0] wr_node [NB];
    logic [BW-1:0] wr_beat [NB];
    int            cyc;

    function automatic string test_label(input logic [3:0] id);
        case (id)
            4'd1: return "reset_state";
            4'd2: return "write_read";
            4'd3: return "parallel_banks";
            4'd4: return "stream";
            4'd5: return "busy_available";
            default: return "idle";
        endcase
    endfunction

    // a vector sits at {node, beat}
    function automatic logic [W-1:0] expected_beat(input int bank, input logic [NW-1:0] node,
                                                   input logic [BW-1:0] beat);
        return shadow[bank][{node, beat}];
    endfunction

    task automatic check_value(input string what, input logic [W-1:0] exp,
                               input logic [W-1:0] act);
        if (act !== exp) begin
            value_errs++;
            $display("FAILED %s %s: expected %h, actual %h", test_label(test_id), what, exp, act);
        end
    endtask

    task automatic order_error(input string what, input int bank);
        order_errs++;
        $display("ERROR %s: %s on bank %0d at cycle %0d", test_label(test_id), what, bank, cyc);
    endtask

    task automatic push_beats(input int q, input int first, input int nodes,
                              input logic [NW-1:0] node0, input logic [`FV_TAG_W-1:0] tag);
        beat_t e;
        for (int i = 0; i < nodes * `FV_BEATS; i++) begin
            e.cyc  = first + i;
            e.node = node0 + NW'(i / `FV_BEATS);
            e.beat = BW'(i % `FV_BEATS);
            e.sos  = (i % `FV_BEATS == 0);
            e.eos  = (i % `FV_BEATS == `FV_BEATS - 1);
            e.tag  = tag;
            exp_q[q].push_back(e);
        end
    endtask

    task automatic compare_port(input int q, input string name, input logic v, input logic sos,
                                input logic eos, input logic [NW-1:0] id, input logic [W-1:0] data);
        beat_t e;
        int    b;
        string where;
        b = q % NB;
        where = $sformatf("bank %0d %s", b, name);
        while (exp_q[q].size() > 0 && exp_q[q][0].cyc < cyc) begin
            void'(exp_q[q].pop_front());
            order_error({"missing ", name, " beat"}, b);
        end
        if (!v) begin
            if (sos || eos) begin
                order_error({name, " sos or eos without valid"}, b);
            end
        end else if (exp_q[q].size() == 0 || exp_q[q][0].cyc != cyc) begin
            order_error({"unexpected ", name, " beat"}, b);
        end else begin
            e = exp_q[q].pop_front();
            check_value({where, "_data"}, expected_beat(b, e.node, e.beat), data);
            check_value({where, " sos/eos"}, W'({e.sos, e.eos}), W'({sos, eos}));
            check_value({where, "_id"}, (q < NB) ? W'(e.tag) : W'(e.node), W'(id));
        end
    endtask

    initial begin
        value_errs = 0;
        order_errs = 0;
        pending = 0;
        cyc = 0;
    end

    // outputs seen here belong to this cycle and inputs to the next edge
    always @(negedge clk) begin
        logic exp_avail;
        int   e;
        if (rst_n !== 1'b1) begin
            for (int b = 0; b < NB; b++) begin
                busy_to[b] = -1;
                wr_act[b] = 1'b0;
                exp_q[b].delete();
                exp_q[b + NB].delete();
            end
        end else begin
            exp_avail = 1'b1;
            for (int b = 0; b < NB; b++) begin
                exp_avail = exp_avail && !wr_act[b] && (cyc + 1 > busy_to[b]);
            end
            check_value("available", W'(exp_avail), W'(available));
            for (int b = 0; b < NB; b++) begin
                compare_port(b, "rd", rd_valid[b], rd_sos[b], rd_eos[b], NW'(rd_tag[b]),
                             rd_data[b]);
                compare_port(b + NB, "st", st_valid[b], st_sos[b], st_eos[b], st_node[b],
                             st_data[b]);
            end
            e = cyc + 1;
            for (int b = 0; b < NB; b++) begin
                if (wr_act[b]) begin
                    if (req_valid[b] && req_op[b]) begin
                        shadow[b][{wr_node[b], wr_beat[b]}] = req_data[b];
                        wr_beat[b] = wr_beat[b] + 1'b1;
                        wr_act[b] = !req_wr_eos[b];
                    end
                end else if (e > busy_to[b]) begin
                    // stream pulse first, then read, then the sos beat of a write
                    if (stream_begin && fv_num != '0) begin
                        push_beats(b + NB, e + 2, int'(fv_num), '0, '0);
                        busy_to[b] = e + 2 + int'(fv_num) * `FV_BEATS;
                    end else if (req_valid[b] && !req_op[b]) begin
                        push_beats(b, e + 2, 1, req_node_id[b], req_pe_tag[b]);
                        busy_to[b] = e + 2 + `FV_BEATS;
                    end else if (req_valid[b] && req_wr_sos[b]) begin
                        shadow[b][{req_node_id[b], BW'(0)}] = req_data[b];
                        wr_node[b] = req_node_id[b];
                        wr_beat[b] = BW'(1);
                        wr_act[b] = !req_wr_eos[b];
                    end
                end
            end
        end
        pending = 0;
        for (int q = 0; q < 2 * NB; q++) begin
            pending += exp_q[q].size();
        end
        cyc++;
    end

endmodule

//--- test/tb_fv_buffer.sv
// ********************
// testbench of the large feature-vector buffer
// ********************
`timescale 1ns/1ns
`include "fv_defines.svh"

module tb_fv_buffer;

    localparam int NB         = `FV_NUM_BANKS;
    localparam int NW         = `FV_NODE_W;
    localparam int TW         = `FV_TAG_W;
    localparam int NUMW       = `FV_NODE_W + 1;
    localparam int CLK_PERIOD = 8;
    // reset check, 12 write/read pairs, 12 parallel ops, 4 streams, busy cases
    localparam int NUM_OPS    = 48;

    logic                          clk;
    logic                          rst_n;
    logic [3:0]                    test_id;
    logic [NB-1:0]                 req_valid;
    logic [NB-1:0]                 req_op;
    logic [NB-1:0]                 req_wr_sos;
    logic [NB-1:0]                 req_wr_eos;
    logic [NB-1:0][TW-1:0]         req_pe_tag;
    logic [NB-1:0][NW-1:0]         req_node_id;
    logic [NB-1:0][`FV_WIDTH-1:0]  req_data;
    logic                          stream_begin;
    logic [NUMW-1:0]               fv_num;
    logic [NB-1:0]                 rd_valid;
    logic [NB-1:0]                 rd_sos;
    logic [NB-1:0]                 rd_eos;
    logic [NB-1:0][TW-1:0]         rd_tag;
    logic [NB-1:0][`FV_WIDTH-1:0]  rd_data;
    logic [NB-1:0]                 st_valid;
    logic [NB-1:0]                 st_sos;
    logic [NB-1:0]                 st_eos;
    logic [NB-1:0][NW-1:0]         st_node;
    logic [NB-1:0][`FV_WIDTH-1:0]  st_data;
    logic                          available;
    logic [31:0]                   rng_state;
    int                            value_errs;
    int                            order_errs;
    int                            pending;

    fv_buffer_top u_dut (.*);

    fv_checker u_check (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(NUM_OPS * (`FV_BEATS * 64 + 10) * CLK_PERIOD);
        $display("ERROR: watchdog timeout, the run did not finish");
        $display("STATUS: FAIL");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic clear_inputs();
        req_valid = '0;
        req_op = '0;
        req_wr_sos = '0;
        req_wr_eos = '0;
        req_pe_tag = '0;
        req_node_id = '0;
        req_data = '0;
    endtask

    // 1 ns past the next rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_available();
        next_cycle();
        while (!available) begin
            next_cycle();
        end
    endtask

    task automatic send_write(input logic [NB-1:0] mask, input logic [NB-1:0][NW-1:0] nodes);
        wait_available();
        for (int k = 0; k < `FV_BEATS; k++) begin
            req_valid = mask;
            req_op = mask;
            req_wr_sos = (k == 0) ? mask : '0;
            req_wr_eos = (k == `FV_BEATS - 1) ? mask : '0;
            req_node_id = nodes;
            for (int b = 0; b < NB; b++) begin
                req_data[b] = next_rand();
            end
            next_cycle();
        end
        clear_inputs();
    endtask

    // without when_free the request goes out at once even to a busy bank
    task automatic send_read(input logic [NB-1:0] mask, input logic [NB-1:0][NW-1:0] nodes,
                             input logic [NB-1:0][TW-1:0] tags, input bit when_free);
        if (when_free) begin
            wait_available();
        end
        req_valid = mask;
        req_op = '0;
        req_node_id = nodes;
        req_pe_tag = tags;
        next_cycle();
        clear_inputs();
    endtask

    task automatic send_stream(input logic [NUMW-1:0] num);
        wait_available();
        stream_begin = 1'b1;
        fv_num = num;
        next_cycle();
        stream_begin = 1'b0;
    endtask

    initial begin
        logic [NB-1:0][NW-1:0] nodes;
        logic [NB-1:0][TW-1:0] tags;
        logic [31:0]           r;
        int                    bank;
        int                    end_errs;
        end_errs = 0;
        rng_state = 32'd18583;
        rst_n = 1'b0;
        test_id = 4'd1;
        stream_begin = 1'b0;
        fv_num = '0;
        clear_inputs();
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (4) next_cycle();

        test_id = 4'd2;
        repeat (12) begin
            r = next_rand();
            bank = int'(r[7:0]) % NB;
            nodes = '0;
            tags = '0;
            nodes[bank] = r[8 +: NW];
            tags[bank] = r[16 +: TW];
            send_write(NB'(1) << bank, nodes);
            send_read(NB'(1) << bank, nodes, tags, 1'b1);
        end

        // nodes 0 to 7 of every bank also feed the streams
        test_id = 4'd3;
        for (int n = 0; n < 8; n++) begin
            for (int b = 0; b < NB; b++) begin
                nodes[b] = NW'(n);
            end
            send_write('1, nodes);
        end
        for (int i = 0; i < 4; i++) begin
            for (int b = 0; b < NB; b++) begin
                nodes[b] = NW'((i + b) % 8);
                tags[b] = TW'(b ^ i);
            end
            send_read('1, nodes, tags, 1'b1);
        end

        test_id = 4'd4;
        repeat (3) begin
            r = next_rand();
            send_stream(NUMW'(1 + r % 8));
        end
        send_stream('0);
        repeat (8) next_cycle();

        test_id = 4'd5;
        nodes = '0;
        tags = '0;
        nodes[2] = NW'(3);
        tags[2] = TW'(1);
        send_read(NB'(4), nodes, tags, 1'b1);
        next_cycle();
        // second read lands while bank 2 is still busy
        nodes[2] = NW'(5);
        send_read(NB'(4), nodes, tags, 1'b0);
        nodes = '0;
        nodes[1] = NW'(9);
        send_write(NB'(2), nodes);
        // read in the cycle after eos sees the new vector
        send_read(NB'(2), nodes, tags, 1'b0);
        send_stream(NUMW'(2));
        send_read(NB'(1), nodes, tags, 1'b0);

        wait_available();
        repeat (4) next_cycle();
        if (pending != 0) begin
            end_errs++;
            $display("ERROR: %0d expected beats never arrived", pending);
        end
        $display("errors: value %0d, order %0d, end %0d", value_errs, order_errs, end_errs);
        if (value_errs + order_errs + end_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
